// File: src/credit_pkg.sv
// credit tracking types for the token return path
// gray pointers cross from the token clock into clk_i, credit counts
// live in clk_i, and the edge select names one token polarity

`include "link_defs.svh"

package credit_pkg;

  // tokens per polarity are 2^(LG_FIFO_DEPTH-1-LG_DECIMATION)
  // the pointer carries one extra bit so a full wrap is still visible
  localparam int PTR_W = `LG_FIFO_DEPTH - `LG_DECIMATION;

  // a credit count must hold a whole buffer's worth
  localparam int CNT_W = `LG_FIFO_DEPTH;

  typedef logic [PTR_W-1:0] gray_ptr_t;
  typedef logic [CNT_W-1:0] credit_cnt_t;

  // each polarity starts out owning half of the receive buffer
  localparam credit_cnt_t INIT_CREDITS = credit_cnt_t'(1) << (`LG_FIFO_DEPTH - 1);

  // which token edge a counter watches, or which one the sender draws from
  typedef enum logic {
    EDGE_RISE = 1'b0,
    EDGE_FALL = 1'b1
  } edge_sel_e;

  function automatic gray_ptr_t bin_to_gray(input gray_ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  function automatic gray_ptr_t gray_to_bin(input gray_ptr_t gray);
    gray_ptr_t bin;
    // the top bit is shared, every lower bit folds in the one above it
    bin[PTR_W-1] = gray[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: src/link_defs.svh
// link configuration macros
// word width, receive buffer depth and how many credits one token edge carries
// every RTL file that sizes something from these includes this header

`ifndef LINK_DEFS_SVH
`define LINK_DEFS_SVH

// width of one data word on the link
`define LINK_WIDTH 16

// log2 of the receiver buffer depth
// the sender starts with this many credits split evenly over the two token edges
`define LG_FIFO_DEPTH 3

// log2 of the credits returned by a single token edge
// must stay at most LG_FIFO_DEPTH - 1 so each polarity owns at least one token
`define LG_DECIMATION 1

`endif

// File: src/link_downstream.sv
// link receiver
// buffers every valid flit, hands words to the consumer on valid/yumi and
// toggles the token line once per decimated group of dequeues

`include "link_defs.svh"

module link_downstream (
  input  logic            clk_i,
  input  logic            rst_i,
  input  link_pkg::flit_t flit_i,
  output logic            out_v_o,
  output link_pkg::word_t out_data_o,
  input  logic            out_yumi_i,
  output logic            token_clk_o,
  output logic            token_rst_o
);

  localparam int DEPTH = 1 << `LG_FIFO_DEPTH;
  localparam logic [`LG_DECIMATION:0] GROUP_LAST = (1 << `LG_DECIMATION) - 1;

  link_pkg::word_t mem_r [DEPTH];

  // pointers carry a wrap bit above the index so full and empty differ
  logic [`LG_FIFO_DEPTH:0] wr_ptr_r;
  logic [`LG_FIFO_DEPTH:0] rd_ptr_r;

  logic [`LG_DECIMATION:0] dec_cnt_r;
  logic                    group_done;

  logic rst_d_r;
  logic token_clk_r;
  logic token_rst_r;

  // the sender's credits guarantee there is always room for a valid flit
  always_ff @(posedge clk_i) begin
    if (flit_i.valid) begin
      mem_r[wr_ptr_r[`LG_FIFO_DEPTH-1:0]] <= flit_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
    end else begin
      if (flit_i.valid) begin
        wr_ptr_r <= wr_ptr_r + 1'b1;
      end
      if (out_yumi_i) begin
        rd_ptr_r <= rd_ptr_r + 1'b1;
      end
    end
  end

  assign out_v_o    = (wr_ptr_r != rd_ptr_r);
  assign out_data_o = mem_r[rd_ptr_r[`LG_FIFO_DEPTH-1:0]];

  // last dequeue of a group frees enough room to return one token edge
  assign group_done = out_yumi_i && (dec_cnt_r == GROUP_LAST);

  // remembers that reset was high last cycle, which stretches the token reset
  always_ff @(posedge clk_i) begin
    rst_d_r     <= rst_i;
    token_rst_r <= rst_i | rst_d_r;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      dec_cnt_r <= '0;
      // toggle during reset so the token domain flops see edges
      // the first reset cycle parks the line low to get a known level
      if (rst_d_r) begin
        token_clk_r <= ~token_clk_r;
      end else begin
        token_clk_r <= 1'b0;
      end
    end else if (rst_d_r) begin
      // extra cycle with token reset still high, hold the line low
      token_clk_r <= 1'b0;
    end else if (out_yumi_i) begin
      if (group_done) begin
        dec_cnt_r   <= '0;
        token_clk_r <= ~token_clk_r;
      end else begin
        dec_cnt_r <= dec_cnt_r + 1'b1;
      end
    end
  end

  assign token_clk_o = token_clk_r;
  assign token_rst_o = token_rst_r;

endmodule

// File: src/link_pkg.sv
// data path types of the link
// the word carried from core to consumer and the single-word flit
// that crosses from sender to receiver

`include "link_defs.svh"

package link_pkg;

  // one payload word as the core hands it over
  typedef logic [`LINK_WIDTH-1:0] word_t;

  // one transfer on the link wires
  // valid is a single-cycle strobe, there is no back-pressure wire
  typedef struct packed {
    logic  valid;
    word_t data;
  } flit_t;

endpackage

// File: src/link_top.sv
// source synchronous link with credit tracked sender
// the sender and receiver meet through the flit wires and the token line
// which runs back as its own clock

module link_top (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            in_v_i,
  input  link_pkg::word_t in_data_i,
  output logic            in_ready_o,
  output logic            out_v_o,
  output link_pkg::word_t out_data_o,
  input  logic            out_yumi_i
);

  link_pkg::flit_t link_flit;
  logic            token_clk;
  logic            token_rst;

  link_upstream u_upstream (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .in_v_i     (in_v_i),
    .in_data_i  (in_data_i),
    .in_ready_o (in_ready_o),
    .flit_o     (link_flit),
    .token_clk_i(token_clk),
    .token_rst_i(token_rst)
  );

  link_downstream u_downstream (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .flit_i     (link_flit),
    .out_v_o    (out_v_o),
    .out_data_o (out_data_o),
    .out_yumi_i (out_yumi_i),
    .token_clk_o(token_clk),
    .token_rst_o(token_rst)
  );

endmodule

// File: src/link_upstream.sv
// credit tracked link sender
// buffers core words in a two entry FIFO and puts one on the link only while
// a credit is held, drawing groups alternately from rising and falling tokens

`include "link_defs.svh"

module link_upstream (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            in_v_i,
  input  link_pkg::word_t in_data_i,
  output logic            in_ready_o,
  output link_pkg::flit_t flit_o,
  input  logic            token_clk_i,
  input  logic            token_rst_i
);

  logic            fifo_v;
  link_pkg::word_t fifo_data;
  logic            send;

  // top bit picks the polarity, lower bits count sends within a group
  logic [`LG_DECIMATION:0] alt_r;
  credit_pkg::edge_sel_e   sel_edge;

  logic rise_avail;
  logic fall_avail;
  logic sel_credit_avail;
  logic rise_dec;
  logic fall_dec;

  link_pkg::flit_t flit_n;

  two_entry_fifo u_fifo (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .v_i    (in_v_i),
    .data_i (in_data_i),
    .ready_o(in_ready_o),
    .v_o    (fifo_v),
    .data_o (fifo_data),
    .yumi_i (send)
  );

  // starts at zero so the first group is drawn from rising edge credits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      alt_r <= '0;
    end else if (send) begin
      alt_r <= alt_r + 1'b1;
    end
  end

  assign sel_edge = credit_pkg::edge_sel_e'(alt_r[`LG_DECIMATION]);

  assign sel_credit_avail = (sel_edge == credit_pkg::EDGE_FALL) ? fall_avail : rise_avail;

  // a word goes out when there is one and the current polarity has a credit
  // the same strobe dequeues it from the buffer
  assign send = fifo_v & sel_credit_avail;

  assign rise_dec = send & (sel_edge == credit_pkg::EDGE_RISE);
  assign fall_dec = send & (sel_edge == credit_pkg::EDGE_FALL);

  token_credit_counter #(
    .COUNT_FALLING(1'b0)
  ) u_rise_ctr (
    .token_clk_i   (token_clk_i),
    .token_rst_i   (token_rst_i),
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dec_i         (rise_dec),
    .credit_avail_o(rise_avail)
  );

  token_credit_counter #(
    .COUNT_FALLING(1'b1)
  ) u_fall_ctr (
    .token_clk_i   (token_clk_i),
    .token_rst_i   (token_rst_i),
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .dec_i         (fall_dec),
    .credit_avail_o(fall_avail)
  );

  assign flit_n.valid = send;
  assign flit_n.data  = fifo_data;

  // keep the link wires quiet while the block is held in reset
  assign flit_o = rst_i ? '0 : flit_n;

endmodule

// File: src/token_credit_counter.sv
// credit counter for one polarity of the returned token clock
// the token itself clocks a gray pointer, which is synchronized into clk_i
// and turned into a count of credits the sender may still spend

`include "link_defs.svh"

module token_credit_counter #(
  parameter bit COUNT_FALLING = 1'b0
) (
  input  logic token_clk_i,
  input  logic token_rst_i,
  input  logic clk_i,
  input  logic rst_i,
  input  logic dec_i,
  output logic credit_avail_o
);

  localparam credit_pkg::edge_sel_e WATCH_EDGE =
    (COUNT_FALLING != 1'b0) ? credit_pkg::EDGE_FALL : credit_pkg::EDGE_RISE;

  // token domain pointer, already in gray code
  credit_pkg::gray_ptr_t w_gray_r;
  credit_pkg::gray_ptr_t w_gray_next;

  // two flop synchronizer into clk_i
  credit_pkg::gray_ptr_t sync1_r;
  credit_pkg::gray_ptr_t sync2_r;
  credit_pkg::gray_ptr_t recv_bin;

  // credits spent so far, wraps together with the scaled receive count
  credit_pkg::credit_cnt_t used_r;
  credit_pkg::credit_cnt_t recv_credits;
  credit_pkg::credit_cnt_t avail;

  // step the pointer in binary and store it back as gray
  // so only one bit ever changes per token edge
  assign w_gray_next = credit_pkg::bin_to_gray(
    credit_pkg::gray_ptr_t'(credit_pkg::gray_to_bin(w_gray_r) + 1'b1));

  // the token line is used as a clock because its phase against clk_i is unknown
  // each polarity gets its own counter instead of a dual edge flop
  generate
    if (WATCH_EDGE == credit_pkg::EDGE_FALL) begin : g_fall
      always_ff @(negedge token_clk_i) begin
        if (token_rst_i) begin
          w_gray_r <= '0;
        end else begin
          w_gray_r <= w_gray_next;
        end
      end
    end else begin : g_rise
      always_ff @(posedge token_clk_i) begin
        if (token_rst_i) begin
          w_gray_r <= '0;
        end else begin
          w_gray_r <= w_gray_next;
        end
      end
    end
  endgenerate

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_r <= '0;
      sync2_r <= '0;
    end else begin
      sync1_r <= w_gray_r;
      sync2_r <= sync1_r;
    end
  end

  assign recv_bin = credit_pkg::gray_to_bin(sync2_r);

  // one token edge stands for a whole group of credits
  assign recv_credits = credit_pkg::credit_cnt_t'(recv_bin) << `LG_DECIMATION;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      used_r <= '0;
    end else if (dec_i) begin
      used_r <= used_r + 1'b1;
    end
  end

  // modular difference, never more than INIT_CREDITS outstanding
  assign avail = credit_pkg::INIT_CREDITS + recv_credits - used_r;

  assign credit_avail_o = (avail != '0);

endmodule

// File: src/two_entry_fifo.sv
// two entry buffer between the core and the link sender
// valid/ready on the write side, valid/yumi on the read side
// ready and valid both come straight from state flops

module two_entry_fifo (
  input  logic            clk_i,
  input  logic            rst_i,
  input  logic            v_i,
  input  link_pkg::word_t data_i,
  output logic            ready_o,
  output logic            v_o,
  output link_pkg::word_t data_o,
  input  logic            yumi_i
);

  // payload storage, only ever written on an accepted word
  link_pkg::word_t mem_r [2];

  logic rd_ptr_r;
  logic wr_ptr_r;
  // ready_r means not full, v_r means not empty
  logic ready_r;
  logic v_r;

  logic enq;
  logic deq;

  assign enq = v_i & ready_r;
  // the reader only raises yumi while v_o is high
  assign deq = yumi_i;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rd_ptr_r <= 1'b0;
      wr_ptr_r <= 1'b0;
      ready_r  <= 1'b1;
      v_r      <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r <= ~wr_ptr_r;
      end
      if (deq) begin
        rd_ptr_r <= ~rd_ptr_r;
      end
      // occupancy only moves when exactly one side is active
      if (enq && !deq) begin
        v_r <= 1'b1;
        // a second word in means the buffer is now full
        ready_r <= ~v_r;
      end else if (deq && !enq) begin
        ready_r <= 1'b1;
        // removing the last word leaves it empty
        v_r <= ~ready_r;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  assign ready_o = ready_r;
  assign v_o     = v_r;
  assign data_o  = mem_r[rd_ptr_r];

endmodule

// File: test/link_sva.sv
// assertions on the link receiver buffer and the sender credit logic
// the same checker is bound into both sides
// inputs that belong to the other side are tied off at each bind

`include "link_defs.svh"

module link_sva (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic [`LG_FIFO_DEPTH:0] wr_ptr_i,
  input logic [`LG_FIFO_DEPTH:0] rd_ptr_i,
  input logic                    rx_write_i,
  input logic                    out_v_i,
  input logic                    out_yumi_i,
  input logic                    send_i,
  input credit_pkg::credit_cnt_t credit_i
);

  logic rx_full;

  // number of assertion failures seen by this instance
  int err_cnt = 0;

  // full when the indices match and the wrap bits differ
  assign rx_full = (wr_ptr_i ^ rd_ptr_i) == {1'b1, {`LG_FIFO_DEPTH{1'b0}}};

  no_write_when_full: assert property (
    @(posedge clk_i) disable iff (rst_i) rx_write_i |-> !rx_full
  ) else begin
    $error("flit written into a full receive buffer");
    err_cnt++;
  end

  // a send draws on the selected polarity, whose count can never climb
  // above the credits it started with
  send_needs_credit: assert property (
    @(posedge clk_i) disable iff (rst_i)
      send_i |-> (credit_i != '0) && (credit_i <= credit_pkg::INIT_CREDITS)
  ) else begin
    $error("flit sent without a valid credit in the selected polarity");
    err_cnt++;
  end

  yumi_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i) out_yumi_i |-> out_v_i
  ) else begin
    $error("consumer dequeued while the receive buffer was empty");
    err_cnt++;
  end

endmodule

bind link_downstream link_sva u_rx_sva (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .wr_ptr_i  (wr_ptr_r),
  .rd_ptr_i  (rd_ptr_r),
  .rx_write_i(flit_i.valid),
  .out_v_i   (out_v_o),
  .out_yumi_i(out_yumi_i),
  .send_i    (1'b0),
  .credit_i  ('0)
);

bind link_upstream link_sva u_tx_sva (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .wr_ptr_i  ('0),
  .rd_ptr_i  ('0),
  .rx_write_i(1'b0),
  .out_v_i   (1'b0),
  .out_yumi_i(1'b0),
  .send_i    (flit_o.valid),
  .credit_i  ((sel_edge == credit_pkg::EDGE_FALL) ? u_fall_ctr.avail : u_rise_ctr.avail)
);

// File: test/link_tb.sv
// testbench for the credit tracked link
// drives random traffic through link_top and checks every delivered word
// against a queue model of what the core handed over

`include "link_defs.svh"

module link_tb;

  // every test moves at most this many words, used to size the timeout
  localparam int TOTAL_WORDS = 200 + 10 + 100 + 150;
  localparam int CYCLE_LIMIT = 20 * TOTAL_WORDS + 200;

  logic            clk_i;
  logic            rst_i;
  logic            in_v_i;
  link_pkg::word_t in_data_i;
  logic            in_ready_o;
  logic            out_v_o;
  link_pkg::word_t out_data_o;
  logic            out_yumi_i;

  integer          seed = 32'h93ea;
  link_pkg::word_t model_q[$];
  link_pkg::word_t exp_word;
  string           cur_test = "none";
  int              accepted = 0;
  int              errors = 0;
  int              pass_cnt = 0;
  int              fail_cnt = 0;
  int              cycle_cnt = 0;
  int              sva_seen = 0;
  int              errs_before;

  link_top u_link_top (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .in_v_i    (in_v_i),
    .in_data_i (in_data_i),
    .in_ready_o(in_ready_o),
    .out_v_o   (out_v_o),
    .out_data_o(out_data_o),
    .out_yumi_i(out_yumi_i)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // true with roughly pct percent probability
  function automatic bit chance(input int pct);
    return ($unsigned($random(seed)) % 100) < pct;
  endfunction

  // failures seen so far by the checkers bound into both sides of the link
  function automatic int bound_failures();
    return u_link_top.u_downstream.u_rx_sva.err_cnt +
           u_link_top.u_upstream.u_tx_sva.err_cnt;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      errors++;
    end
  endtask

  // mid cycle every handshake signal is settled, so this is when the model samples
  always @(negedge clk_i) begin
    if (rst_i === 1'b0) begin
      if (in_v_i && in_ready_o) begin
        model_q.push_back(in_data_i);
        accepted++;
      end
      if (out_v_o && out_yumi_i) begin
        assert (model_q.size() != 0) else begin
          $display("%s: the consumer got a word that the core never sent", cur_test);
          errors++;
        end
        if (model_q.size() != 0) begin
          exp_word = model_q.pop_front();
          check_value(cur_test, exp_word, out_data_o);
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("run stopped after %0d cycles, the link stopped moving words", cycle_cnt);
      $display("Test FAILED");
      $finish;
    end
  end

  // the link must stay idle for the whole reset
  task automatic apply_reset();
    rst_i      = 1'b1;
    in_v_i     = 1'b0;
    out_yumi_i = 1'b0;
    repeat (5) begin
      @(posedge clk_i);
      #1;
      check_value(cur_test, 0, out_v_o);
    end
    rst_i = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  // random valid and yumi until n_words more went in and the queue is empty
  task automatic run_traffic(input int n_words, input int in_pct, input int yumi_pct);
    int acc_base;
    int last_acc;
    acc_base = accepted;
    last_acc = accepted;
    while ((accepted - acc_base) < n_words || model_q.size() != 0) begin
      @(posedge clk_i);
      #1;
      // a word on offer is held until it has been taken
      if (!in_v_i || accepted != last_acc) begin
        in_v_i    = ((accepted - acc_base) < n_words) && chance(in_pct);
        in_data_i = link_pkg::word_t'($random(seed));
      end
      last_acc   = accepted;
      out_yumi_i = out_v_o && chance(yumi_pct);
    end
    in_v_i     = 1'b0;
    out_yumi_i = 1'b0;
    // every word the core handed over is out, so the receiver must be empty
    check_value(cur_test, 0, out_v_o);
  endtask

  // no dequeues, so only the initial credits plus the sender buffer can fill
  task automatic run_capacity();
    int acc_base;
    int low_cycles;
    int last_acc;
    acc_base   = accepted;
    low_cycles = 0;
    last_acc   = accepted;
    out_yumi_i = 1'b0;
    in_v_i     = 1'b1;
    in_data_i  = link_pkg::word_t'($random(seed));
    while (low_cycles < 50) begin
      @(posedge clk_i);
      #1;
      if (accepted != last_acc) begin
        in_data_i = link_pkg::word_t'($random(seed));
      end
      last_acc = accepted;
      if (in_ready_o) begin
        low_cycles = 0;
      end else begin
        low_cycles++;
      end
    end
    check_value(cur_test, (1 << `LG_FIFO_DEPTH) + 2, accepted - acc_base);
  endtask

  task automatic finish_test();
    int new_sva;
    new_sva = bound_failures() - sva_seen;
    if (new_sva != 0) begin
      $display("%s: bound assertions failed %0d times", cur_test, new_sva);
      sva_seen = sva_seen + new_sva;
      errors   = errors + new_sva;
    end
    if (errors == errs_before) begin
      pass_cnt++;
      $display("[%s] passed", cur_test);
    end else begin
      fail_cnt++;
      $display("[%s] failed with %0d errors", cur_test, errors - errs_before);
    end
  endtask

  initial begin
    rst_i      = 1'b1;
    in_v_i     = 1'b0;
    in_data_i  = '0;
    out_yumi_i = 1'b0;

    cur_test    = "reset_idle";
    errs_before = errors;
    apply_reset();
    check_value(cur_test, 1, in_ready_o);
    check_value(cur_test, 0, out_v_o);
    check_value(cur_test, 0, u_link_top.link_flit.valid);
    finish_test();

    cur_test    = "ordered_delivery";
    errs_before = errors;
    run_traffic(200, 70, 70);
    finish_test();

    // a fresh reset leaves both token polarities with their full credits
    cur_test    = "capacity";
    errs_before = errors;
    apply_reset();
    run_capacity();
    finish_test();

    cur_test    = "credit_return";
    errs_before = errors;
    run_traffic(100, 70, 100);
    finish_test();

    cur_test    = "slow_consumer";
    errs_before = errors;
    run_traffic(150, 70, 10);
    finish_test();

    $display("summary: %0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+src
src/link_pkg.sv
src/credit_pkg.sv
src/two_entry_fifo.sv
src/token_credit_counter.sv
src/link_upstream.sv
src/link_downstream.sv
src/link_top.sv
test/link_sva.sv
test/link_tb.sv
